// ==== all.f ====
+incdir+source
source/ex_pkg.sv
source/alu.sv
source/mult.sv
source/csr_buffer.sv
source/sfence_capture.sv
source/flu_writeback.sv
source/ex_stage.sv
tests/ex_stage_properties.sv
tests/tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_ex_stage -Mdir obj_dir -o sim_ex_stage

status=0
output=$(./obj_dir/sim_ex_stage +verilator+error+limit+1000) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== tests/tb_ex_stage.sv ====
`include "ex_cfg.svh"

module tb_ex_stage import ex_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES  = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + STIM_CYCLES + 3;

    logic      clk_i;
    logic      rst_ni;
    logic      flush_i;
    logic      alu_valid_i;
    logic      csr_valid_i;
    logic      mult_valid_i;
    logic      csr_commit_i;
    fu_data_t  fu_data_i;
    vaddr_t    rs1_forwarding_i;
    xlen_t     rs2_forwarding_i;
    xlen_t     flu_result_o;
    trans_id_t flu_trans_id_o;
    logic      flu_valid_o;
    logic      flu_ready_o;
    csr_addr_t csr_addr_o;
    vaddr_t    vaddr_to_flush_o;
    asid_t     asid_to_flush_o;

    logic [31:0] seed;
    int          tb_errors = 0;

    ex_stage dut (.*);

    bind ex_stage ex_stage_properties props (.*);

    function automatic logic [31:0] xorshift32();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    // ------------------------------
    // Clock and watchdog
    // ------------------------------
    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    initial begin
        #((TOTAL_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the run did not reach its end in the expected time");
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [`EX_XLEN-1:0] r;
        logic                mult_prev;
        int                  kind;
        seed             = 32'hfdf3;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        alu_valid_i      = 1'b0;
        csr_valid_i      = 1'b0;
        mult_valid_i     = 1'b0;
        csr_commit_i     = 1'b0;
        fu_data_i        = '0;
        rs1_forwarding_i = '0;
        rs2_forwarding_i = '0;
        mult_prev        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        check_value("flu_valid_o", 32'(flu_valid_o), 32'h0);
        check_value("flu_ready_o", 32'(flu_ready_o), 32'h1);
        check_value("vaddr_to_flush_o", vaddr_to_flush_o, 32'h0);
        check_value("asid_to_flush_o", 32'(asid_to_flush_o), 32'h0);
        #4;
        rst_ni = 1'b1;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(posedge clk_i);
            #5;
            r            = xorshift32();
            kind         = int'(r[10:8]);
            alu_valid_i  = 1'b0;
            csr_valid_i  = 1'b0;
            mult_valid_i = 1'b0;
            csr_commit_i = !flu_ready_o && (r[3:2] == 2'b00);
            flush_i      = (r[7:4] == 4'hf);
            fu_data_i.operation = fu_op_e'({1'b0, r[13:11]});
            fu_data_i.operand_a = xorshift32();
            fu_data_i.operand_b = xorshift32();
            fu_data_i.trans_id  = r[16:14];
            rs1_forwarding_i    = xorshift32();
            rs2_forwarding_i    = xorshift32();
            // Write-back port belongs to the multiplier after a MUL
            if (mult_prev) begin
                mult_valid_i = (kind < 4);
            end else if (kind < 3) begin
                alu_valid_i = 1'b1;
            end else if (kind == 3) begin
                mult_valid_i = 1'b1;
            end else if (kind < 6 && flu_ready_o) begin
                csr_valid_i = 1'b1;
                fu_data_i.operation = (kind == 4) ? OP_CSRRW : OP_SFENCE_VMA;
            end
            if (mult_valid_i) begin
                fu_data_i.operation = OP_MUL;
            end
            mult_prev = mult_valid_i;
        end
        @(posedge clk_i);
        #5;
        {flush_i, alu_valid_i, csr_valid_i, mult_valid_i, csr_commit_i} = '0;
        repeat (2) @(posedge clk_i);
        #5;
        $display("Errors: %0d testbench checks, %0d assertions", tb_errors,
            dut.props.fail_count);
        if (tb_errors == 0 && dut.props.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/ex_stage_properties.sv ====
`include "ex_cfg.svh"

module ex_stage_properties import ex_pkg::*; (
    input logic      clk_i,
    input logic      rst_ni,
    input logic      flush_i,
    input logic      alu_valid_i,
    input logic      csr_valid_i,
    input logic      mult_valid_i,
    input logic      csr_commit_i,
    input fu_data_t  fu_data_i,
    input vaddr_t    rs1_forwarding_i,
    input xlen_t     rs2_forwarding_i,
    input xlen_t     flu_result_o,
    input trans_id_t flu_trans_id_o,
    input logic      flu_valid_o,
    input logic      flu_ready_o,
    input csr_addr_t csr_addr_o,
    input vaddr_t    vaddr_to_flush_o,
    input asid_t     asid_to_flush_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;
    logic        sfence_issue;
    logic        sfence_held_q;
    logic [63:0] product;

    // Reference model of the ALU operations
    function automatic xlen_t alu_expect(input fu_data_t d);
        xlen_t res;
        res = '0;
        case (d.operation)
            OP_ADD: res = d.operand_a + d.operand_b;
            OP_SUB: res = d.operand_a + ~d.operand_b + 32'd1;
            OP_AND: res = d.operand_a & d.operand_b;
            OP_OR:  res = d.operand_a | d.operand_b;
            OP_XOR: res = d.operand_a ^ d.operand_b;
            OP_SLL: res = d.operand_a << d.operand_b[4:0];
            OP_SRL: res = d.operand_a >> d.operand_b[4:0];
            OP_SLT: begin
                // Different signs decide on their own
                if (d.operand_a[`EX_XLEN-1] != d.operand_b[`EX_XLEN-1]) begin
                    res = xlen_t'(d.operand_a[`EX_XLEN-1]);
                end else begin
                    res = xlen_t'(d.operand_a < d.operand_b);
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    assign product      = {32'b0, fu_data_i.operand_a} * {32'b0, fu_data_i.operand_b};
    assign sfence_issue = csr_valid_i && (fu_data_i.operation == OP_SFENCE_VMA);

    // Sfence pending until the flush that follows it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sfence_held_q <= 1'b0;
        end else if (flush_i) begin
            sfence_held_q <= 1'b0;
        end else if (sfence_issue) begin
            sfence_held_q <= 1'b1;
        end
    end

    // ------------------------------
    // Write-back port
    // ------------------------------
    a_alu: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alu_valid_i |-> flu_valid_o && flu_result_o == alu_expect(fu_data_i)
            && flu_trans_id_o == fu_data_i.trans_id)
    else begin
        $error("Fail ALU: flu_valid_o %h, flu_result_o %h exp %h, flu_trans_id_o %h exp %h",
            flu_valid_o, flu_result_o, alu_expect(fu_data_i), flu_trans_id_o,
            fu_data_i.trans_id);
        fail_count++;
    end

    a_csr_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> flu_valid_o && flu_result_o == fu_data_i.operand_a
            && flu_trans_id_o == fu_data_i.trans_id)
    else begin
        $error("Fail CSR: flu_valid_o %h, flu_result_o %h exp %h, flu_trans_id_o %h exp %h",
            flu_valid_o, flu_result_o, fu_data_i.operand_a, flu_trans_id_o,
            fu_data_i.trans_id);
        fail_count++;
    end

    // Result one cycle later unless a flush hits either cycle
    a_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> ((flush_i || $past(flush_i)) ? !flu_valid_o :
            (flu_valid_o && flu_result_o == $past(product[31:0])
            && flu_trans_id_o == $past(fu_data_i.trans_id))))
    else begin
        $error("Fail MUL: flu_valid_o %h, flu_result_o %h, flu_trans_id_o %h",
            flu_valid_o, flu_result_o, flu_trans_id_o);
        fail_count++;
    end

    a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !alu_valid_i && !csr_valid_i && !$past(mult_valid_i) |-> !flu_valid_o)
    else begin
        $error("Write-back valid without any result");
        fail_count++;
    end

    // ------------------------------
    // CSR buffer
    // ------------------------------
    a_csr_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i && !flush_i |=> !flu_ready_o
            && csr_addr_o == $past(fu_data_i.operand_b[`EX_CSR_ADDR_BITS-1:0]))
    else begin
        $error("Fail CSR fill: flu_ready_o %h, csr_addr_o %h", flu_ready_o, csr_addr_o);
        fail_count++;
    end

    a_csr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !flu_ready_o && !csr_commit_i && !flush_i |=> !flu_ready_o && $stable(csr_addr_o))
    else begin
        $error("CSR buffer left full state without commit or flush");
        fail_count++;
    end

    a_csr_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !flu_ready_o && (csr_commit_i || flush_i) |=> flu_ready_o)
    else begin
        $error("CSR buffer still full after commit or flush");
        fail_count++;
    end

    // ------------------------------
    // SFENCE.VMA operands
    // ------------------------------
    a_sfence_freeze: assert property (@(posedge clk_i) disable iff (!rst_ni)
        sfence_held_q || sfence_issue |=> $stable(vaddr_to_flush_o)
            && $stable(asid_to_flush_o))
    else begin
        $error("Fail sfence hold: vaddr_to_flush_o %h, asid_to_flush_o %h",
            vaddr_to_flush_o, asid_to_flush_o);
        fail_count++;
    end

    a_sfence_track: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !sfence_held_q && !sfence_issue |=> vaddr_to_flush_o == $past(rs1_forwarding_i)
            && asid_to_flush_o == $past(rs2_forwarding_i[`EX_ASID_WIDTH-1:0]))
    else begin
        $error("Fail sfence track: vaddr_to_flush_o %h, asid_to_flush_o %h",
            vaddr_to_flush_o, asid_to_flush_o);
        fail_count++;
    end

endmodule

// ==== source/ex_stage.sv ====
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      alu_valid_i,
    input  logic      csr_valid_i,
    input  logic      mult_valid_i,
    input  logic      csr_commit_i,
    input  fu_data_t  fu_data_i,
    input  vaddr_t    rs1_forwarding_i,
    input  xlen_t     rs2_forwarding_i,
    output xlen_t     flu_result_o,
    output trans_id_t flu_trans_id_o,
    output logic      flu_valid_o,
    output logic      flu_ready_o,
    output csr_addr_t csr_addr_o,
    output vaddr_t    vaddr_to_flush_o,
    output asid_t     asid_to_flush_o
);

    fu_data_t  alu_data;
    fu_data_t  mult_data;
    xlen_t     alu_result;
    xlen_t     csr_result;
    xlen_t     mult_result;
    trans_id_t mult_trans_id;
    logic      mult_valid;
    logic      csr_ready;

    // ------------------------------
    // Shared write-back port
    // ------------------------------
    flu_writeback i_flu_writeback (
        .alu_valid_i     (alu_valid_i),
        .csr_valid_i     (csr_valid_i),
        .mult_valid_i    (mult_valid_i),
        .mult_done_i     (mult_valid),
        .csr_ready_i     (csr_ready),
        .fu_data_i       (fu_data_i),
        .alu_result_i    (alu_result),
        .csr_result_i    (csr_result),
        .mult_result_i   (mult_result),
        .mult_trans_id_i (mult_trans_id),
        .alu_data_o      (alu_data),
        .mult_data_o     (mult_data),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o),
        .flu_valid_o     (flu_valid_o),
        .flu_ready_o     (flu_ready_o)
    );

    // Single cycle ALU
    alu i_alu (
        .fu_data_i (alu_data),
        .result_o  (alu_result)
    );

    // One cycle multiplier
    mult i_mult (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .fu_data_i       (mult_data),
        .result_o        (mult_result),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id)
    );

    // Single entry CSR buffer
    csr_buffer i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .fu_data_i    (fu_data_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    // SFENCE.VMA operand capture for the TLB flush
    sfence_capture i_sfence_capture (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .csr_valid_i      (csr_valid_i),
        .fu_data_i        (fu_data_i),
        .rs1_forwarding_i (rs1_forwarding_i),
        .rs2_forwarding_i (rs2_forwarding_i),
        .vaddr_to_flush_o (vaddr_to_flush_o),
        .asid_to_flush_o  (asid_to_flush_o)
    );

endmodule

// ==== source/flu_writeback.sv ====
module flu_writeback import ex_pkg::*; (
    input  logic      alu_valid_i,
    input  logic      csr_valid_i,
    input  logic      mult_valid_i,
    input  logic      mult_done_i,
    input  logic      csr_ready_i,
    input  fu_data_t  fu_data_i,
    input  xlen_t     alu_result_i,
    input  xlen_t     csr_result_i,
    input  xlen_t     mult_result_i,
    input  trans_id_t mult_trans_id_i,
    output fu_data_t  alu_data_o,
    output fu_data_t  mult_data_o,
    output xlen_t     flu_result_o,
    output trans_id_t flu_trans_id_o,
    output logic      flu_valid_o,
    output logic      flu_ready_o
);

    // ------------------------------
    // Operand silencing
    // ------------------------------
    // Idle units see an all-zero issue bundle
    assign alu_data_o  = alu_valid_i  ? fu_data_i : '0;
    assign mult_data_o = mult_valid_i ? fu_data_i : '0;

    // ------------------------------
    // Result merge
    // ------------------------------
    // Priority ALU, then CSR, then multiplier
    always_comb begin
        flu_result_o   = '0;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_done_i) begin
            // Tag was captured at issue
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    assign flu_valid_o = alu_valid_i | csr_valid_i | mult_done_i;

    // Only the CSR buffer can block issue
    assign flu_ready_o = csr_ready_i;

endmodule

// ==== source/sfence_capture.sv ====
module sfence_capture import ex_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     csr_valid_i,
    input  fu_data_t fu_data_i,
    input  vaddr_t   rs1_forwarding_i,
    input  xlen_t    rs2_forwarding_i,
    output vaddr_t   vaddr_to_flush_o,
    output asid_t    asid_to_flush_o
);

    logic   sfence_issue;
    logic   sfence_pending_q;
    vaddr_t vaddr_q;
    asid_t  asid_q;

    assign sfence_issue = csr_valid_i && (fu_data_i.operation == OP_SFENCE_VMA);

    // Pending until the pipeline flush that follows the sfence
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sfence_pending_q <= 1'b0;
        end else if (flush_i) begin
            sfence_pending_q <= 1'b0;
        end else if (sfence_issue) begin
            sfence_pending_q <= 1'b1;
        end
    end

    // ------------------------------
    // Flush operands
    // ------------------------------
    // Track rs1/rs2 every cycle, freeze once the sfence shows up
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vaddr_q <= '0;
            asid_q  <= '0;
        end else if (!sfence_pending_q && !sfence_issue) begin
            vaddr_q <= rs1_forwarding_i;
            asid_q  <= asid_t'(rs2_forwarding_i);
        end
    end

    assign vaddr_to_flush_o = vaddr_q;
    assign asid_to_flush_o  = asid_q;

endmodule

// ==== source/csr_buffer.sv ====
module csr_buffer import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      csr_valid_i,
    input  logic      csr_commit_i,
    input  fu_data_t  fu_data_i,
    output logic      csr_ready_o,
    output xlen_t     csr_result_o,
    output csr_addr_t csr_addr_o
);

    csr_state_e state_d, state_q;
    csr_addr_t  addr_q;

    // Next state of the single entry
    always_comb begin
        state_d = state_q;
        if (state_q == CSR_FULL && csr_commit_i) begin
            state_d = CSR_EMPTY;
        end
        if (csr_valid_i) begin
            state_d = CSR_FULL;
        end
        // Flush wins over everything else
        if (flush_i) begin
            state_d = CSR_EMPTY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CSR_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // CSR address sits in the low bits of operand b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= csr_addr_t'(fu_data_i.operand_b);
        end
    end

    assign csr_ready_o  = (state_q == CSR_EMPTY);
    assign csr_addr_o   = addr_q;
    assign csr_result_o = fu_data_i.operand_a;

endmodule

// ==== source/mult.sv ====
module mult import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      mult_valid_i,
    input  fu_data_t  fu_data_i,
    output xlen_t     result_o,
    output logic      mult_valid_o,
    output trans_id_t mult_trans_id_o
);

    logic      valid_q;
    xlen_t     result_q;
    trans_id_t trans_id_q;

    // ------------------------------
    // Valid pipeline
    // ------------------------------
    // A new product may enter every cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    // ------------------------------
    // Product and tag
    // ------------------------------
    // Low word of the product only
    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= fu_data_i.operand_a * fu_data_i.operand_b;
            trans_id_q <= fu_data_i.trans_id;
        end
    end

    assign result_o        = result_q;
    assign mult_trans_id_o = trans_id_q;

    // Flush in the write-back cycle also kills the result
    assign mult_valid_o = valid_q & ~flush_i;

endmodule

// ==== source/alu.sv ====
module alu import ex_pkg::*; (
    input  fu_data_t fu_data_i,
    output xlen_t    result_o
);

    logic [4:0] shamt;
    logic       less_than;

    // Only the low five bits matter for a 32 bit shift
    assign shamt = fu_data_i.operand_b[4:0];

    // Signed compare for SLT
    assign less_than = $signed(fu_data_i.operand_a) < $signed(fu_data_i.operand_b);

    // ------------------------------
    // Operation decode
    // ------------------------------
    always_comb begin
        result_o = '0;
        case (fu_data_i.operation)
            OP_ADD: begin
                result_o = fu_data_i.operand_a + fu_data_i.operand_b;
            end
            OP_SUB: begin
                result_o = fu_data_i.operand_a - fu_data_i.operand_b;
            end
            OP_AND: begin
                result_o = fu_data_i.operand_a & fu_data_i.operand_b;
            end
            OP_OR: begin
                result_o = fu_data_i.operand_a | fu_data_i.operand_b;
            end
            OP_XOR: begin
                result_o = fu_data_i.operand_a ^ fu_data_i.operand_b;
            end
            OP_SLL: begin
                result_o = fu_data_i.operand_a << shamt;
            end
            OP_SRL: begin
                result_o = fu_data_i.operand_a >> shamt;
            end
            OP_SLT: begin
                result_o[0] = less_than;
            end
            // Non-ALU operations leave the result at zero
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== source/ex_pkg.sv ====
`include "ex_cfg.svh"

package ex_pkg;

    // ------------------------------
    // Width types
    // ------------------------------
    typedef logic [`EX_XLEN-1:0]          xlen_t;
    typedef logic [`EX_VLEN-1:0]          vaddr_t;
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`EX_ASID_WIDTH-1:0]    asid_t;
    typedef logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_t;

    // ------------------------------
    // Operations
    // ------------------------------
    typedef enum logic [3:0] {
        OP_ADD        = 4'd0,
        OP_SUB        = 4'd1,
        OP_AND        = 4'd2,
        OP_OR         = 4'd3,
        OP_XOR        = 4'd4,
        OP_SLL        = 4'd5,
        OP_SRL        = 4'd6,
        OP_SLT        = 4'd7,
        OP_MUL        = 4'd8,
        OP_CSRRW      = 4'd9,
        OP_SFENCE_VMA = 4'd10
    } fu_op_e;

    // Occupancy of the single CSR entry
    typedef enum logic {
        CSR_EMPTY = 1'b0,
        CSR_FULL  = 1'b1
    } csr_state_e;

    // Issue bundle shared by all fixed latency units
    typedef struct packed {
        fu_op_e    operation;
        xlen_t     operand_a;
        xlen_t     operand_b;
        trans_id_t trans_id;
    } fu_data_t;

endpackage

// ==== source/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Integer data path width
`define EX_XLEN 32

// Virtual address width seen by the TLB flush
`define EX_VLEN 32

// Scoreboard tag width
`define EX_TRANS_ID_BITS 3

// Address space identifier width
`define EX_ASID_WIDTH 4

// CSR address field of the instruction
`define EX_CSR_ADDR_BITS 12

`endif
